/* flist.f */
+incdir+.
i8008_pkg.sv
i8008_ifs.sv
i8008_alu.sv
i8008_flow.sv
i8008_sequencer.sv
i8008_top.sv
tb_i8008.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and fail when the log holds the fail message.
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_i8008 -o tb_sim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { echo "simulation did not run"; exit 1; }
cat sim.log
! grep -q "RESULT: FAIL" sim.log && grep -q "RESULT: PASS" sim.log && exit 0 || exit 1

/* i8008_model.svh */
////////////////////////////////////////////////////////////////////////////
// Reference instruction-set model of the 8008 subset used by the testbench.
// Runs a program from a memory copy and records the expected bus writes.
////////////////////////////////////////////////////////////////////////////

`ifndef I8008_MODEL_SVH
`define I8008_MODEL_SVH

logic [7:0]  m_mem [65536];
logic [7:0]  m_regs [7];
logic [13:0] m_stack [8];
logic [2:0]  m_sp;
logic [13:0] m_pc;
flags_t      m_flags;
logic [15:0] exp_adr_q [$];
logic [7:0]  exp_dat_q [$];

function automatic flags_t update_zsp(flags_t f, logic [7:0] r);
  flags_t n;
  n = f;
  n.zero = (r == 8'h00);
  n.sign = r[7];
  n.parity = ~^r;
  return n;
endfunction

// Low two code bits select the flag, bit 2 the polarity.
function automatic logic cond_true(logic [2:0] c);
  logic f;
  case (c[1:0])
    2'd0: f = m_flags.carry;
    2'd1: f = m_flags.zero;
    2'd2: f = m_flags.sign;
    default: f = m_flags.parity;
  endcase
  return f == c[2];
endfunction

function automatic logic [7:0] fetch_byte();
  logic [7:0] b;
  b = m_mem[{2'b00, m_pc}];
  m_pc = m_pc + 14'd1;
  return b;
endfunction

task automatic store_byte(logic [15:0] a, logic [7:0] d);
  m_mem[a] = d;
  exp_adr_q.push_back(a);
  exp_dat_q.push_back(d);
endtask

task automatic alu_step(logic [2:0] o, logic [7:0] b);
  logic [8:0] s;
  logic [7:0] a;
  a = m_regs[0];
  case (o)
    3'd0: s = {1'b0, a} + {1'b0, b};
    3'd1: s = {1'b0, a} + {1'b0, b} + {8'h00, m_flags.carry};
    3'd2, 3'd7: s = {1'b0, a} - {1'b0, b};
    3'd3: s = {1'b0, a} - {1'b0, b} - {8'h00, m_flags.carry};
    3'd4: s = {1'b0, a & b};
    3'd5: s = {1'b0, a ^ b};
    default: s = {1'b0, a | b};
  endcase
  m_flags = update_zsp(m_flags, s[7:0]);
  m_flags.carry = s[8];
  // Compare keeps the accumulator.
  if (o != 3'd7) m_regs[0] = s[7:0];
endtask

task automatic rotate_acc(logic [1:0] k);
  logic [7:0] a;
  logic c;
  a = m_regs[0];
  c = m_flags.carry;
  case (k)
    2'd0: begin
      m_flags.carry = a[7];
      a = {a[6:0], a[7]};
    end
    2'd1: begin
      m_flags.carry = a[0];
      a = {a[0], a[7:1]};
    end
    2'd2: begin
      m_flags.carry = a[7];
      a = {a[6:0], c};
    end
    default: begin
      m_flags.carry = a[0];
      a = {c, a[7:1]};
    end
  endcase
  m_regs[0] = a;
endtask

task automatic run_model();
  logic [7:0] op;
  logic [7:0] lo;
  logic [7:0] hi;
  logic [15:0] hl;
  int steps;
  for (int i = 0; i < 65536; i++) m_mem[i] = mem[i];
  for (int i = 0; i < 7; i++) m_regs[i] = 8'h00;
  m_pc = `I8008_RESET_PC;
  m_sp = 3'd0;
  m_flags = '0;
  exp_adr_q.delete();
  exp_dat_q.delete();
  steps = 0;
  op = 8'h00;
  while (steps < 5000 && op != 8'hFF) begin
    op = fetch_byte();
    steps++;
    hl = {m_regs[5], m_regs[6]};
    case (op[7:6])
      2'b11: begin
        if (op == 8'hFF) begin
          // HLT ends the run.
        end else if (op[5:3] == 3'd7) store_byte(hl, m_regs[op[2:0]]);
        else if (op[2:0] == 3'd7) m_regs[op[5:3]] = m_mem[hl];
        else m_regs[op[5:3]] = m_regs[op[2:0]];
      end
      2'b10: alu_step(op[5:3], (op[2:0] == 3'd7) ? m_mem[hl] : m_regs[op[2:0]]);
      2'b01: begin
        lo = fetch_byte();
        hi = fetch_byte();
        if (op[2] || cond_true(op[5:3])) begin
          if (op[1]) begin
            m_stack[m_sp] = m_pc;
            m_sp = m_sp + 3'd1;
          end
          m_pc = {hi[5:0], lo};
        end
      end
      default: begin
        case (op[2:0])
          3'd0: begin
            m_regs[op[5:3]] = m_regs[op[5:3]] + 8'd1;
            m_flags = update_zsp(m_flags, m_regs[op[5:3]]);
          end
          3'd1: begin
            m_regs[op[5:3]] = m_regs[op[5:3]] - 8'd1;
            m_flags = update_zsp(m_flags, m_regs[op[5:3]]);
          end
          3'd2: rotate_acc(op[4:3]);
          3'd4: alu_step(op[5:3], fetch_byte());
          3'd6: begin
            lo = fetch_byte();
            if (op[5:3] == 3'd7) store_byte(hl, lo);
            else m_regs[op[5:3]] = lo;
          end
          default: begin
            // Returns are conditional when bit 2 is clear.
            if (op[2] || cond_true(op[5:3])) begin
              m_sp = m_sp - 3'd1;
              m_pc = m_stack[m_sp];
            end
          end
        endcase
      end
    endcase
  end
endtask

`endif

/* tb_i8008.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the 8008 core: clock, reset, Wishbone memory with waits,
// random program generator, model comparison and result report.
////////////////////////////////////////////////////////////////////////////

`include "i8008_cfg.svh"

module tb_i8008
  import i8008_pkg::*;
();

  localparam int AW = `I8008_ADDR_W;
  localparam int DW = `I8008_DATA_W;
  localparam int NUM_TESTS = 40;
  localparam int HALT_TIMEOUT = 20000;
  localparam logic [15:0] FLAG_ADR = 16'h20FF;

  logic raw_clk;
  logic button_reset;
  logic wb_cyc, wb_stb, wb_we, wb_ack, halted;
  logic [AW-1:0] wb_adr;
  logic [DW-1:0] wb_dat_o, wb_dat_i;

  logic [7:0] mem [65536];
  logic [AW-1:0] dut_adr_q [$];
  logic [DW-1:0] dut_dat_q [$];
  logic [13:0] gen_pc;
  string test_name;
  int seed;
  int errors;
  int bus_cycles;
  int waits;
  logic busy, first_pending;
  logic [AW-1:0] hold_adr;
  logic [DW-1:0] hold_dat;
  logic hold_we;

  `include "i8008_model.svh"

  i8008_top dut_i (.*);

  initial begin
    raw_clk = 1'b0;
    forever #50 raw_clk = ~raw_clk;
  end

  function automatic int rnd(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic logic [7:0] enc(int g, int mid, int lo);
    return {2'(g), 3'(mid), 3'(lo)};
  endfunction

  task automatic emit(logic [7:0] b);
    mem[{2'b00, gen_pc}] = b;
    gen_pc = gen_pc + 14'd1;
  endtask

  task automatic emit_addr(logic [13:0] a);
    emit(a[7:0]);
    emit({2'b00, a[13:8]});
  endtask

  // Subroutines at 0x1000 call one level deeper and may return early.
  task automatic gen_program();
    logic [13:0] t;
    for (int i = 0; i < 65536; i++) mem[i] = 8'(i) ^ 8'(i >> 8);
    for (int i = 16'h2000; i < 16'h2100; i++) mem[i] = 8'(rnd(256));
    for (int k = 0; k < 4; k++) begin
      gen_pc = 14'(16'h1000 + k * 64);
      emit(8'h08);
      emit(8'hF9);
      if (k < 3) begin
        emit(rnd(2) != 0 ? 8'h46 : enc(1, rnd(8), 2));
        emit_addr(14'(16'h1000 + (k + 1) * 64));
      end
      emit(enc(0, rnd(8), 3));
      emit(8'hFA);
      emit(8'h07);
    end
    gen_pc = `I8008_RESET_PC;
    for (int r = 0; r < 5; r++) begin
      emit(enc(0, r, 6));
      emit(8'(rnd(256)));
    end
    emit(8'h2E);
    emit(8'h20);
    emit(8'h36);
    emit(8'(rnd(255)));
    for (int n = 12 + rnd(12); n > 0; n--) begin
      case (rnd(10))
        0: emit(enc(2, rnd(8), rnd(7)));
        1: emit(enc(2, rnd(8), 7));
        2: begin
          emit(enc(0, rnd(8), 4));
          emit(8'(rnd(256)));
        end
        3: emit(enc(0, 1 + rnd(4), rnd(2)));
        4: emit(enc(0, rnd(4), 2));
        5: emit(enc(3, rnd(5), rnd(7)));
        6: begin
          case (rnd(3))
            0: emit(enc(3, rnd(5), 7));
            1: emit(enc(3, 7, rnd(7)));
            default: begin
              emit(8'h3E);
              emit(8'(rnd(256)));
            end
          endcase
        end
        7: begin
          // Jump over a store, so the write list shows the branch.
          t = gen_pc + 14'd4;
          emit(enc(1, rnd(8), 0));
          emit_addr(t);
          emit(8'hF8);
        end
        8: begin
          emit(rnd(2) != 0 ? 8'h46 : enc(1, rnd(8), 2));
          emit_addr(14'h1000);
        end
        default: begin
          if (rnd(2) != 0) begin
            emit(8'hF8);
          end else begin
            emit(8'h36);
            emit(8'(rnd(255)));
          end
        end
      endcase
    end
    // Final A, then one marker write per set flag.
    emit(8'hF8);
    emit(8'h36);
    emit(8'hFF);
    for (int i = 0; i < 4; i++) begin
      t = gen_pc + 14'd5;
      emit(enc(1, i, 0));
      emit_addr(t);
      emit(8'h3E);
      emit(8'hA0 | 8'(i));
    end
    emit(8'hFF);
  endtask

  // Wishbone slave with 0 to 3 wait cycles.
  always @(posedge raw_clk) begin
    if (!button_reset) begin
      wb_ack <= 1'b0;
      busy = 1'b0;
      first_pending = 1'b1;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        busy = 1'b1;
        hold_adr = wb_adr;
        hold_we = wb_we;
        hold_dat = wb_dat_o;
        waits = rnd(4);
        bus_cycles++;
        if (first_pending && (wb_we || wb_adr != AW'(`I8008_RESET_PC))) begin
          $display("error %s first bus cycle: expected read at %h actual we=%b at %h",
                   test_name, AW'(`I8008_RESET_PC), wb_we, wb_adr);
          errors++;
        end
        first_pending = 1'b0;
      end else if (wb_adr != hold_adr || wb_we != hold_we ||
                   (hold_we && wb_dat_o != hold_dat)) begin
        $display("%s: bus signals changed before ack in the cycle at %h",
                 test_name, hold_adr);
        errors++;
      end
      if (waits == 0) begin
        wb_ack <= 1'b1;
        busy = 1'b0;
        if (hold_we) begin
          mem[hold_adr] = hold_dat;
          dut_adr_q.push_back(hold_adr);
          dut_dat_q.push_back(hold_dat);
        end else begin
          wb_dat_i <= mem[hold_adr];
        end
      end else begin
        waits--;
      end
    end else if (busy) begin
      $display("%s: bus cycle at %h ended before ack", test_name, hold_adr);
      errors++;
      busy = 1'b0;
    end
  end

  task automatic compare_write(string name, int idx, logic [AW-1:0] exp_a,
                               logic [DW-1:0] exp_d, logic [AW-1:0] act_a,
                               logic [DW-1:0] act_d);
    if (exp_a !== act_a || exp_d !== act_d) begin
      $display("error %s write %0d: expected %h=%h actual %h=%h",
               name, idx, exp_a, exp_d, act_a, act_d);
      errors++;
    end
  endtask

  task automatic compare_flags(string name, flags_t exp_f, flags_t act_f);
    if (exp_f !== act_f) begin
      $display("error %s flags: expected %b actual %b", name, exp_f, act_f);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge raw_clk);
    button_reset <= 1'b0;
    repeat (10) @(posedge raw_clk);
    button_reset <= 1'b1;
  endtask

  task automatic wait_halted(output logic ok);
    int n;
    n = 0;
    while (!halted && n < HALT_TIMEOUT) begin
      @(negedge raw_clk);
      n++;
    end
    ok = halted;
  endtask

  initial begin
    logic ok, timed_out;
    int errs0, passed, failed, c0;
    flags_t act_f;
    button_reset = 1'b0;
    wb_ack = 1'b0;
    wb_dat_i = '0;
    seed = 32'h78b531b0;
    errors = 0;
    bus_cycles = 0;
    passed = 0;
    failed = 0;
    timed_out = 1'b0;
    test_name = "";
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      test_name = $sformatf("test_%0d", t);
      errs0 = errors;
      gen_program();
      run_model();
      dut_adr_q.delete();
      dut_dat_q.delete();
      apply_reset();
      wait_halted(ok);
      if (!ok) begin
        $display("%s: timeout waiting for halted", test_name);
        timed_out = 1'b1;
      end else begin
        c0 = bus_cycles;
        repeat (40) @(negedge raw_clk);
        if (bus_cycles != c0 || wb_cyc || !halted) begin
          $display("%s: bus cycle started or halted dropped after HLT", test_name);
          errors++;
        end
        if (dut_adr_q.size() != exp_adr_q.size()) begin
          $display("error %s write count: expected %0d actual %0d",
                   test_name, exp_adr_q.size(), dut_adr_q.size());
          errors++;
        end
        for (int i = 0; i < dut_adr_q.size() && i < exp_adr_q.size(); i++)
          compare_write(test_name, i, exp_adr_q[i], exp_dat_q[i],
                        dut_adr_q[i], dut_dat_q[i]);
        act_f = '0;
        foreach (dut_adr_q[i]) begin
          if (dut_adr_q[i] == FLAG_ADR && dut_dat_q[i][7:2] == 6'b101000) begin
            case (dut_dat_q[i][1:0])
              2'd0: act_f.carry = 1'b1;
              2'd1: act_f.zero = 1'b1;
              2'd2: act_f.sign = 1'b1;
              default: act_f.parity = 1'b1;
            endcase
          end
        end
        compare_flags(test_name, m_flags, act_f);
      end
      if (errors == errs0 && !timed_out) begin
        passed++;
        $display("%s passed, %0d writes", test_name, dut_adr_q.size());
      end else begin
        failed++;
        $display("%s failed", test_name);
      end
    end
    $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* i8008_top.sv */
////////////////////////////////////////////////////////////////////////////
// Top level of the 8008 soft processor.
// Sequencer, ALU and flow unit behind a Wishbone classic master port.
////////////////////////////////////////////////////////////////////////////

`include "i8008_cfg.svh"

module i8008_top (
  input  logic                     raw_clk,
  input  logic                     button_reset,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output logic [`I8008_ADDR_W-1:0] wb_adr,
  output logic [`I8008_DATA_W-1:0] wb_dat_o,
  input  logic [`I8008_DATA_W-1:0] wb_dat_i,
  input  logic                     wb_ack,
  output logic                     halted
);

  alu_if  alu_bus ();
  flow_if flow_bus ();

  i8008_sequencer seq_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .alu          (alu_bus.seq),
    .flow         (flow_bus.seq),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_o     (wb_dat_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack       (wb_ack),
    .halted       (halted)
  );

  i8008_alu alu_i (
    .alu (alu_bus.alu)
  );

  i8008_flow flow_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .flow         (flow_bus.flow)
  );

endmodule

/* i8008_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Sequencer of the 8008 core.
// Fetch and decode FSM, register file, flags, PC and Wishbone master.
////////////////////////////////////////////////////////////////////////////

`include "i8008_cfg.svh"

module i8008_sequencer
  import i8008_pkg::*;
(
  input  logic                     raw_clk,
  input  logic                     button_reset,
  alu_if.seq                       alu,
  flow_if.seq                      flow,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output logic [`I8008_ADDR_W-1:0] wb_adr,
  output logic [`I8008_DATA_W-1:0] wb_dat_o,
  input  logic [`I8008_DATA_W-1:0] wb_dat_i,
  input  logic                     wb_ack,
  output logic                     halted
);

  localparam int W  = `I8008_DATA_W;
  localparam int AW = `I8008_ADDR_W;
  localparam int PW = `I8008_PC_W;
  localparam logic [PW-1:0] RESET_PC = `I8008_RESET_PC;
  localparam logic [2:0] REG_M = `I8008_REG_M;

  seq_state_t state;
  logic [PW-1:0] pc;
  logic [W-1:0] ir;
  logic [PW-1:0] arg;
  logic [W-1:0] regs [7];
  flags_t flags;

  instr_group_t grp;
  logic [2:0] dst;
  logic [2:0] src;
  logic [AW-1:0] hl;
  logic go;
  logic bus_state;
  logic bus_done;
  logic bus_we;
  logic [AW-1:0] bus_adr;
  logic [W-1:0] bus_dat;

  assign grp = instr_group_t'(ir[7:6]);
  assign dst = ir[5:3];
  assign src = ir[2:0];
  assign hl = {regs[`I8008_REG_H], regs[`I8008_REG_L]};

  // Opcode bit 2 marks the unconditional JMP, CALL and RET forms.
  assign go = src[2] | flow.taken;
  assign bus_done = wb_cyc & wb_ack;
  assign wb_stb = wb_cyc;
  assign halted = (state == S_HALTED);

  // Address and data of the transfer each bus state needs.
  always_comb begin
    bus_state = 1'b1;
    bus_we = 1'b0;
    bus_adr = {{(AW-PW){1'b0}}, pc};
    bus_dat = arg[W-1:0];
    case (state)
      S_FETCH_OP, S_FETCH_LO, S_FETCH_HI, S_FETCH_IM: ;
      S_MEM_RD: bus_adr = hl;
      S_MEM_WR: begin
        bus_we = 1'b1;
        bus_adr = hl;
        // MOV M,r stores a register, MVI M the latched immediate.
        if (grp == GRP_MOV) begin
          bus_dat = regs[src];
        end
      end
      default: bus_state = 1'b0;
    endcase
  end

  // ALU operands. Memory and immediate operands come straight off the bus.
  always_comb begin
    alu.op_a = regs[`I8008_REG_A];
    alu.op_b = regs[src];
    alu.carry_in = flags.carry;
    alu.op = alu_op_t'({1'b0, dst});
    if (state == S_FETCH_IM || state == S_MEM_RD) begin
      alu.op_b = wb_dat_i;
    end
    if (grp == GRP_MISC && src == 3'b000) begin
      alu.op = ALU_INR;
      alu.op_a = regs[dst];
    end else if (grp == GRP_MISC && src == 3'b001) begin
      alu.op = ALU_DCR;
      alu.op_a = regs[dst];
    end else if (grp == GRP_MISC && src == 3'b010) begin
      case (dst[1:0])
        2'b00:   alu.op = ALU_RLC;
        2'b01:   alu.op = ALU_RRC;
        2'b10:   alu.op = ALU_RAL;
        default: alu.op = ALU_RAR;
      endcase
    end
  end

  assign flow.cond = cond_t'(dst);
  assign flow.flags = flags;
  assign flow.push = (state == S_CALL_PUSH);
  assign flow.push_addr = pc;
  assign flow.pop = (state == S_DECODE) && (grp == GRP_MISC) && (src[1:0] == 2'b11) && go;

  task automatic alu_writeback();
    // CMP and CPI only set the flags.
    if (alu.op != ALU_CMP) begin
      regs[`I8008_REG_A] <= alu.result;
    end
    flags <= alu.flags_out;
  endtask

  always_ff @(posedge raw_clk) begin
    if (!button_reset) begin
      state <= S_FETCH_OP;
      pc <= RESET_PC;
      flags <= '0;
      wb_cyc <= 1'b0;
      wb_we <= 1'b0;
    end else begin
      // One transfer at a time, dropped in the cycle after ack.
      if (bus_state && !wb_cyc) begin
        wb_cyc <= 1'b1;
        wb_we <= bus_we;
        wb_adr <= bus_adr;
        wb_dat_o <= bus_dat;
      end else if (bus_done) begin
        wb_cyc <= 1'b0;
        wb_we <= 1'b0;
      end

      case (state)
        S_FETCH_OP: begin
          if (bus_done) begin
            ir <= wb_dat_i;
            pc <= pc + 1'b1;
            state <= S_DECODE;
          end
        end
        S_DECODE: begin
          state <= S_FETCH_OP;
          case (grp)
            GRP_MISC: begin
              case (src)
                3'b000, 3'b001: begin
                  // Code 0 with INR or DCR is HLT, code M is undefined.
                  if (dst == 3'd0 || dst == REG_M) begin
                    state <= S_HALTED;
                  end else begin
                    regs[dst] <= alu.result;
                    flags <= alu.flags_out;
                  end
                end
                3'b010: begin
                  if (dst[2]) begin
                    state <= S_HALTED;
                  end else begin
                    regs[`I8008_REG_A] <= alu.result;
                    flags.carry <= alu.flags_out.carry;
                  end
                end
                3'b011, 3'b111: begin
                  if (go) begin
                    pc <= flow.top_addr;
                  end
                end
                3'b100, 3'b110: state <= S_FETCH_IM;
                default: state <= S_HALTED;
              endcase
            end
            // Odd source codes are IN and OUT, not supported here.
            GRP_FLOW: state <= src[0] ? S_HALTED : S_FETCH_LO;
            GRP_ALU: begin
              if (src == REG_M) begin
                state <= S_MEM_RD;
              end else begin
                alu_writeback();
              end
            end
            default: begin
              if (dst == REG_M && src == REG_M) begin
                state <= S_HALTED;
              end else if (dst == REG_M) begin
                state <= S_MEM_WR;
              end else if (src == REG_M) begin
                state <= S_MEM_RD;
              end else begin
                regs[dst] <= regs[src];
              end
            end
          endcase
        end
        S_FETCH_LO: begin
          if (bus_done) begin
            arg[W-1:0] <= wb_dat_i;
            pc <= pc + 1'b1;
            state <= S_FETCH_HI;
          end
        end
        S_FETCH_HI: begin
          if (bus_done) begin
            arg[PW-1:W] <= wb_dat_i[PW-W-1:0];
            state <= S_FETCH_OP;
            if (go && src[1]) begin
              pc <= pc + 1'b1;
              state <= S_CALL_PUSH;
            end else if (go) begin
              pc <= {wb_dat_i[PW-W-1:0], arg[W-1:0]};
            end else begin
              pc <= pc + 1'b1;
            end
          end
        end
        // Return address goes on the stack while the PC takes the target.
        S_CALL_PUSH: begin
          pc <= arg;
          state <= S_FETCH_OP;
        end
        S_FETCH_IM: begin
          if (bus_done) begin
            pc <= pc + 1'b1;
            state <= S_FETCH_OP;
            if (src == 3'b100) begin
              alu_writeback();
            end else if (dst == REG_M) begin
              arg[W-1:0] <= wb_dat_i;
              state <= S_MEM_WR;
            end else begin
              regs[dst] <= wb_dat_i;
            end
          end
        end
        S_MEM_RD: begin
          if (bus_done) begin
            if (grp == GRP_ALU) begin
              alu_writeback();
            end else begin
              regs[dst] <= wb_dat_i;
            end
            state <= S_FETCH_OP;
          end
        end
        S_MEM_WR: begin
          if (bus_done) begin
            state <= S_FETCH_OP;
          end
        end
        // Halted until reset.
        default: state <= S_HALTED;
      endcase
    end
  end

endmodule

/* i8008_flow.sv */
////////////////////////////////////////////////////////////////////////////
// Flow unit of the 8008 core.
// Condition test against the flags and the return address stack.
////////////////////////////////////////////////////////////////////////////

`include "i8008_cfg.svh"

module i8008_flow
  import i8008_pkg::*;
(
  input logic  raw_clk,
  input logic  button_reset,
  flow_if.flow flow
);

  localparam int PTR_W = $clog2(`I8008_STACK_DEPTH);

  logic [`I8008_PC_W-1:0] stack [`I8008_STACK_DEPTH];
  logic [PTR_W-1:0] sp;
  logic flag_val;

  // Stack pointer wraps in both directions.
  always_ff @(posedge raw_clk) begin
    if (!button_reset) begin
      sp <= '0;
    end else if (flow.push) begin
      sp <= sp + 1'b1;
    end else if (flow.pop) begin
      sp <= sp - 1'b1;
    end
  end

  always_ff @(posedge raw_clk) begin
    if (flow.push) begin
      stack[sp] <= flow.push_addr;
    end
  end

  // Most recent return address.
  assign flow.top_addr = stack[sp - 1'b1];

  // Low two code bits pick the flag under test.
  always_comb begin
    case (flow.cond)
      COND_NC, COND_C: flag_val = flow.flags.carry;
      COND_NZ, COND_Z: flag_val = flow.flags.zero;
      COND_P, COND_M:  flag_val = flow.flags.sign;
      default:         flag_val = flow.flags.parity;
    endcase
  end

  // Codes 4 to 7 are taken on a set flag, codes 0 to 3 on a clear one.
  assign flow.taken = (flag_val == flow.cond[2]);

endmodule

/* i8008_alu.sv */
////////////////////////////////////////////////////////////////////////////
// Combinational ALU of the 8008 core.
// Add, subtract, logic, increment, decrement and rotates with flag outputs.
////////////////////////////////////////////////////////////////////////////

`include "i8008_cfg.svh"

module i8008_alu
  import i8008_pkg::*;
(
  alu_if.alu alu
);

  localparam int W = `I8008_DATA_W;
  localparam logic [W-1:0] ONE = 1;

  // Bit W is the carry, or the borrow for subtraction.
  logic [W:0] wide;
  logic [W-1:0] a;
  logic [W-1:0] b;
  logic cin;

  assign a = alu.op_a;
  assign b = alu.op_b;
  assign cin = alu.carry_in;

  always_comb begin
    case (alu.op)
      ALU_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
      end
      ALU_ADC: begin
        wide = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, cin};
      end
      ALU_SUB, ALU_CMP: begin
        wide = {1'b0, a} - {1'b0, b};
      end
      ALU_SBB: begin
        wide = {1'b0, a} - {1'b0, b} - {{W{1'b0}}, cin};
      end
      // Logic operations clear the carry.
      ALU_ANA: wide = {1'b0, a & b};
      ALU_XRA: wide = {1'b0, a ^ b};
      ALU_ORA: wide = {1'b0, a | b};
      // INR and DCR pass the incoming carry through.
      ALU_INR: wide = {cin, a + ONE};
      ALU_DCR: wide = {cin, a - ONE};
      ALU_RLC: begin
        wide = {a[W-1], a[W-2:0], a[W-1]};
      end
      ALU_RRC: begin
        wide = {a[0], a[0], a[W-1:1]};
      end
      ALU_RAL: begin
        wide = {a[W-1], a[W-2:0], cin};
      end
      ALU_RAR: begin
        wide = {a[0], cin, a[W-1:1]};
      end
      default: begin
        wide = {cin, a};
      end
    endcase
  end

  assign alu.result = wide[W-1:0];

  // Parity flag is set for an even number of ones.
  assign alu.flags_out.carry  = wide[W];
  assign alu.flags_out.zero   = ~|wide[W-1:0];
  assign alu.flags_out.sign   = wide[W-1];
  assign alu.flags_out.parity = ~^wide[W-1:0];

endmodule

/* i8008_ifs.sv */
////////////////////////////////////////////////////////////////////////////
// Internal interfaces of the 8008 core.
// alu_if carries operands and results, flow_if the branch and stack signals.
////////////////////////////////////////////////////////////////////////////

`include "i8008_cfg.svh"

interface alu_if
  import i8008_pkg::*;
();
  logic [`I8008_DATA_W-1:0] op_a;
  logic [`I8008_DATA_W-1:0] op_b;
  alu_op_t                  op;
  logic                     carry_in;
  logic [`I8008_DATA_W-1:0] result;
  flags_t                   flags_out;

  modport seq (output op_a, op_b, op, carry_in, input result, flags_out);
  modport alu (input op_a, op_b, op, carry_in, output result, flags_out);
endinterface

interface flow_if
  import i8008_pkg::*;
();
  cond_t                  cond;
  flags_t                 flags;
  logic                   push;
  logic                   pop;
  logic [`I8008_PC_W-1:0] push_addr;
  logic                   taken;
  logic [`I8008_PC_W-1:0] top_addr;

  modport seq (output cond, flags, push, pop, push_addr, input taken, top_addr);
  modport flow (input cond, flags, push, pop, push_addr, output taken, top_addr);
endinterface

/* i8008_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types of the 8008 core.
// Sequencer states, ALU operations, condition codes, flags and groups.
////////////////////////////////////////////////////////////////////////////

package i8008_pkg;

  // Sequencer states.
  typedef enum logic [4:0] {
    S_FETCH_OP,
    S_DECODE,
    S_FETCH_LO,
    S_FETCH_HI,
    S_FETCH_IM,
    S_MEM_RD,
    S_MEM_WR,
    S_CALL_PUSH,
    S_HALTED
  } seq_state_t;

  // The first eight follow the opcode field order.
  typedef enum logic [3:0] {
    ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB,
    ALU_ANA, ALU_XRA, ALU_ORA, ALU_CMP,
    ALU_INR, ALU_DCR,
    ALU_RLC, ALU_RRC, ALU_RAL, ALU_RAR
  } alu_op_t;

  // Condition codes in encoding order.
  typedef enum logic [2:0] {
    COND_NC, COND_NZ, COND_P, COND_PO,
    COND_C, COND_Z, COND_M, COND_PE
  } cond_t;

  typedef struct packed {
    logic carry;
    logic zero;
    logic sign;
    logic parity;
  } flags_t;

  // Top two opcode bits.
  typedef enum logic [1:0] {
    GRP_MISC = 2'b00,
    GRP_FLOW = 2'b01,
    GRP_ALU  = 2'b10,
    GRP_MOV  = 2'b11
  } instr_group_t;

endpackage

/* i8008_cfg.svh */
////////////////////////////////////////////////////////////////////////////
// Configuration macros for the 8008 core.
// Bus widths, stack depth, reset vector and register field codes.
////////////////////////////////////////////////////////////////////////////

`ifndef I8008_CFG_SVH
`define I8008_CFG_SVH

// Data bus, address bus and program counter widths.
`define I8008_DATA_W 8
`define I8008_ADDR_W 16
`define I8008_PC_W 14

// Depth of the return address stack.
`define I8008_STACK_DEPTH 8

// First opcode fetch address after reset.
`define I8008_RESET_PC 0

// Register field codes. Code M selects the byte at HL.
`define I8008_REG_A 0
`define I8008_REG_H 5
`define I8008_REG_L 6
`define I8008_REG_M 7

`endif
